/* hw/tlb_consts.svh */
/*
 * Field widths, entry count and page-size group boundaries for the TLB
 * match unit. Included by the package and by every RTL file that sizes ports
 */
`ifndef TLB_CONSTS_SVH
`define TLB_CONSTS_SVH

`define TLB_EPN_W     52
`define TLB_PID_W     14
`define TLB_LPID_W    8
`define TLB_THD_W     4
`define TLB_CLS_W     2
`define TLB_SIZE_W    4
`define TLB_ENTRIES   4
`define TLB_IDX_W     2
`define TLB_NGRP      5

// First EPN bit of each page-size group, MSB-first numbering
`define TLB_G1G_LO    34
`define TLB_G256M_LO  36
`define TLB_G16M_LO   40
`define TLB_G1M_LO    44
`define TLB_G64K_LO   48

`endif

/* hw/tlb_pkg.sv */
/*
 * Shared types for the TLB match unit: command opcodes, page-size codes
 * and the layout of one stored entry
 */
`include "tlb_consts.svh"

package tlb_pkg;

   typedef enum logic [1:0] {
      op_nop        = 2'b00,
      op_write      = 2'b01,
      op_search     = 2'b10,
      op_invalidate = 2'b11
   } tlb_op_e;

   // Codes outside this list are rejected on write
   typedef enum logic [`TLB_SIZE_W-1:0] {
      size_4k   = 4'b0001,
      size_64k  = 4'b0011,
      size_1m   = 4'b0101,
      size_16m  = 4'b0111,
      size_256m = 4'b1001,
      size_1g   = 4'b1010
   } tlb_size_e;

   // cmpmask has one bit per group, set when the page covers that group.
   // xmask marks only the group at the page's own size
   typedef struct packed {
      logic                    valid;
      logic [0:`TLB_EPN_W-1]   epn;
      logic [0:`TLB_NGRP-1]    cmpmask;
      logic [0:`TLB_NGRP-1]    xmask;
      logic                    xbit;
      logic [0:`TLB_CLS_W-1]   cls;
      logic                    gs;
      logic                    ts;
      logic [0:`TLB_THD_W-1]   thdid;
      logic [0:`TLB_PID_W-1]   pid;
      logic [0:`TLB_LPID_W-1]  lpid;
   } tlb_entry_t;

endpackage

/* hw/tlb_ifs.sv */
/*
 * Stage-to-stage buses of the TLB pipeline. The command bus runs from
 * decode to execute, the hit bus from execute to result
 */
`timescale 1ns/10ps
`include "tlb_consts.svh"

interface tlb_cmd_if;
   logic                    valid;
   tlb_pkg::tlb_op_e        op;
   logic [`TLB_IDX_W-1:0]   index;
   logic [0:`TLB_EPN_W-1]   epn;
   logic [0:`TLB_NGRP-1]    cmpmask;
   logic [0:`TLB_NGRP-1]    xmask;
   logic                    xbit;
   logic [0:`TLB_CLS_W-1]   cls;
   logic                    gs;
   logic                    ts;
   logic [0:`TLB_THD_W-1]   thdid;
   logic [0:`TLB_PID_W-1]   pid;
   logic [0:`TLB_LPID_W-1]  lpid;
   logic                    class_en;
   logic                    state_en;
   logic                    thdid_en;
   logic                    wild_en;
   logic                    bad_size;

   modport dec (output valid, op, index, epn, cmpmask, xmask, xbit, cls, gs, ts,
                thdid, pid, lpid, class_en, state_en, thdid_en, wild_en, bad_size);
   modport exe (input valid, op, index, epn, cmpmask, xmask, xbit, cls, gs, ts,
                thdid, pid, lpid, class_en, state_en, thdid_en, wild_en, bad_size);
endinterface

interface tlb_hit_if;
   logic                    valid;
   tlb_pkg::tlb_op_e        op;
   logic                    bad_size;
   // Bit i set when entry i matched a search or invalidate
   logic [`TLB_ENTRIES-1:0] hits;

   modport exe (output valid, op, bad_size, hits);
   modport res (input valid, op, bad_size, hits);
endinterface

/* hw/tlb_decode.sv */
/*
 * First pipeline stage. Registers the incoming command, turns the page-size
 * code into the compare and exclusion masks, and sets the field enables
 */
`timescale 1ns/10ps
`include "tlb_consts.svh"

module tlb_decode (
   input  logic                    clk,
   input  logic                    rst,
   input  logic                    cmd_valid,
   input  tlb_pkg::tlb_op_e        cmd_op,
   input  logic [`TLB_IDX_W-1:0]   cmd_index,
   input  logic [0:`TLB_EPN_W-1]   cmd_epn,
   input  logic [`TLB_SIZE_W-1:0]  cmd_size,
   input  logic                    cmd_xbit,
   input  logic [0:`TLB_CLS_W-1]   cmd_class,
   input  logic                    cmd_gs,
   input  logic                    cmd_ts,
   input  logic [0:`TLB_THD_W-1]   cmd_thdid,
   input  logic [0:`TLB_PID_W-1]   cmd_pid,
   input  logic [0:`TLB_LPID_W-1]  cmd_lpid,
   tlb_cmd_if.dec                  cmd
);

   logic [0:`TLB_NGRP-1] size_cmpmask;
   logic [0:`TLB_NGRP-1] size_xmask;
   logic                 size_ok;
   logic                 is_search;

   // Group order in both masks is 1G, 256M, 16M, 1M, 64K
   always_comb
   begin
      {size_ok, size_cmpmask, size_xmask} = '0;
      case (cmd_size)
         tlb_pkg::size_4k:   {size_ok, size_cmpmask, size_xmask} = 11'b1_00000_00000;
         tlb_pkg::size_64k:  {size_ok, size_cmpmask, size_xmask} = 11'b1_00001_00001;
         tlb_pkg::size_1m:   {size_ok, size_cmpmask, size_xmask} = 11'b1_00011_00010;
         tlb_pkg::size_16m:  {size_ok, size_cmpmask, size_xmask} = 11'b1_00111_00100;
         tlb_pkg::size_256m: {size_ok, size_cmpmask, size_xmask} = 11'b1_01111_01000;
         tlb_pkg::size_1g:   {size_ok, size_cmpmask, size_xmask} = 11'b1_11111_10000;
         default:            {size_ok, size_cmpmask, size_xmask} = '0;
      endcase
   end

   assign is_search = (cmd_op == tlb_pkg::op_search);

   always_ff @(posedge clk)
   begin
      if (rst)
      begin
         cmd.valid <= 1'b0;
         cmd.op    <= tlb_pkg::op_nop;
      end
      else
      begin
         cmd.valid <= cmd_valid;
         cmd.op    <= cmd_op;
      end
   end

   // Invalidate compares only address, pid and lpid, and never wildcards
   always_ff @(posedge clk)
   begin
      if (cmd_valid)
      begin
         cmd.index    <= cmd_index;
         cmd.epn      <= cmd_epn;
         cmd.cmpmask  <= size_cmpmask;
         cmd.xmask    <= size_xmask;
         cmd.xbit     <= cmd_xbit;
         cmd.cls      <= cmd_class;
         cmd.gs       <= cmd_gs;
         cmd.ts       <= cmd_ts;
         cmd.thdid    <= cmd_thdid;
         cmd.pid      <= cmd_pid;
         cmd.lpid     <= cmd_lpid;
         cmd.class_en <= is_search;
         cmd.state_en <= is_search;
         cmd.thdid_en <= is_search;
         cmd.wild_en  <= is_search;
         cmd.bad_size <= (cmd_op == tlb_pkg::op_write) && !size_ok;
      end
   end

endmodule

/* hw/tlb_execute.sv */
/*
 * Second pipeline stage. Holds the entry array, applies writes and
 * invalidates, and compares the command against every entry in parallel
 */
`timescale 1ns/10ps
`include "tlb_consts.svh"

module tlb_execute (
   input  logic   clk,
   input  logic   rst,
   tlb_cmd_if.exe cmd,
   tlb_hit_if.exe hit
);

   tlb_pkg::tlb_entry_t     entry_q [`TLB_ENTRIES];
   logic [`TLB_ENTRIES-1:0] match;
   logic                    lookup;

   // One matchline: address with page masking and exclusion, then context
   function automatic logic entry_match (
      input tlb_pkg::tlb_entry_t     e,
      input logic [0:`TLB_EPN_W-1]   addr,
      input logic [0:`TLB_CLS_W-1]   cls,
      input logic                    gs,
      input logic                    ts,
      input logic [0:`TLB_THD_W-1]   thdid,
      input logic [0:`TLB_PID_W-1]   pid,
      input logic [0:`TLB_LPID_W-1]  lpid,
      input logic                    class_en,
      input logic                    state_en,
      input logic                    thdid_en,
      input logic                    wild_en
   );
      logic [0:`TLB_EPN_W-1] eq;
      logic [0:`TLB_EPN_W-1] ex;
      logic                  addr_ok;
      logic                  excl_ok;
      logic                  ctx_ok;
      logic                  id_ok;

      eq = ~(e.epn ^ addr);
      // Positions where the address has a one and the entry EPN a zero
      ex = ~e.epn & addr;

      addr_ok = (&eq[0:`TLB_G1G_LO-1])
              & ((&eq[`TLB_G1G_LO:`TLB_G256M_LO-1]) | e.cmpmask[0])
              & ((&eq[`TLB_G256M_LO:`TLB_G16M_LO-1]) | e.cmpmask[1])
              & ((&eq[`TLB_G16M_LO:`TLB_G1M_LO-1]) | e.cmpmask[2])
              & ((&eq[`TLB_G1M_LO:`TLB_G64K_LO-1]) | e.cmpmask[3])
              & ((&eq[`TLB_G64K_LO:`TLB_EPN_W-1]) | e.cmpmask[4]);

      // With xbit set the page excludes the address range under the EPN's ones
      excl_ok = (~e.xbit | ~e.xmask[0] | (|ex[`TLB_G1G_LO:`TLB_EPN_W-1]))
              & (~e.xbit | ~e.xmask[1] | (|ex[`TLB_G256M_LO:`TLB_EPN_W-1]))
              & (~e.xbit | ~e.xmask[2] | (|ex[`TLB_G16M_LO:`TLB_EPN_W-1]))
              & (~e.xbit | ~e.xmask[3] | (|ex[`TLB_G1M_LO:`TLB_EPN_W-1]))
              & (~e.xbit | ~e.xmask[4] | (|ex[`TLB_G64K_LO:`TLB_EPN_W-1]));

      ctx_ok = ((e.cls == cls) | ~class_en)
             & (((e.gs == gs) & (e.ts == ts)) | ~state_en)
             & ((|(e.thdid & thdid)) | ~thdid_en);

      // A zero id in the entry acts as a wildcard on search only
      id_ok = ((e.pid == pid) | (wild_en & ~(|e.pid)))
            & ((e.lpid == lpid) | (wild_en & ~(|e.lpid)));

      return e.valid & addr_ok & excl_ok & ctx_ok & id_ok;
   endfunction

   genvar i;
   generate
      for (i = 0; i < `TLB_ENTRIES; i++)
      begin : g_match
         assign match[i] = entry_match(entry_q[i], cmd.epn, cmd.cls, cmd.gs, cmd.ts,
                                       cmd.thdid, cmd.pid, cmd.lpid, cmd.class_en,
                                       cmd.state_en, cmd.thdid_en, cmd.wild_en);
      end
   endgenerate

   assign lookup = (cmd.op == tlb_pkg::op_search) || (cmd.op == tlb_pkg::op_invalidate);

   always_ff @(posedge clk)
   begin
      if (rst)
      begin
         for (int k = 0; k < `TLB_ENTRIES; k++)
         begin
            entry_q[k].valid <= 1'b0;
         end
      end
      else if (cmd.valid)
      begin
         if (cmd.op == tlb_pkg::op_write && !cmd.bad_size)
         begin
            entry_q[cmd.index] <= '{valid:   1'b1,
                                    epn:     cmd.epn,
                                    cmpmask: cmd.cmpmask,
                                    xmask:   cmd.xmask,
                                    xbit:    cmd.xbit,
                                    cls:     cmd.cls,
                                    gs:      cmd.gs,
                                    ts:      cmd.ts,
                                    thdid:   cmd.thdid,
                                    pid:     cmd.pid,
                                    lpid:    cmd.lpid};
         end
         else if (cmd.op == tlb_pkg::op_invalidate)
         begin
            for (int k = 0; k < `TLB_ENTRIES; k++)
            begin
               if (match[k])
               begin
                  entry_q[k].valid <= 1'b0;
               end
            end
         end
      end
   end

   always_ff @(posedge clk)
   begin
      if (rst)
      begin
         hit.valid <= 1'b0;
         hit.op    <= tlb_pkg::op_nop;
      end
      else
      begin
         hit.valid <= cmd.valid;
         hit.op    <= cmd.op;
      end
   end

   // Write and nop carry an empty hit vector
   always_ff @(posedge clk)
   begin
      hit.bad_size <= cmd.bad_size;
      hit.hits     <= lookup ? match : '0;
   end

endmodule

/* hw/tlb_result.sv */
/*
 * Last pipeline stage. Reduces the hit vector to hit, lowest index and
 * multi-hit, and drives the registered result outputs
 */
`timescale 1ns/10ps
`include "tlb_consts.svh"

module tlb_result (
   input  logic                  clk,
   input  logic                  rst,
   tlb_hit_if.res                hit,
   output logic                  res_valid,
   output tlb_pkg::tlb_op_e      res_op,
   output logic                  res_hit,
   output logic [`TLB_IDX_W-1:0] res_index,
   output logic                  res_multi,
   output logic                  res_err
);

   logic [`TLB_IDX_W-1:0] low_index;
   logic                  multi;

   // Scan from the top so the lowest hitting entry wins
   always_comb
   begin
      low_index = '0;
      for (int i = `TLB_ENTRIES-1; i >= 0; i--)
      begin
         if (hit.hits[i])
         begin
            low_index = `TLB_IDX_W'(i);
         end
      end
   end

   // Clearing the lowest set bit leaves something only if two or more were set
   assign multi = |(hit.hits & (hit.hits - 1'b1));

   always_ff @(posedge clk)
   begin
      if (rst)
      begin
         res_valid <= 1'b0;
         res_op    <= tlb_pkg::op_nop;
         res_hit   <= 1'b0;
         res_multi <= 1'b0;
         res_err   <= 1'b0;
      end
      else
      begin
         res_valid <= hit.valid;
         res_op    <= hit.op;
         res_hit   <= |hit.hits;
         res_multi <= multi;
         res_err   <= hit.bad_size && (hit.op == tlb_pkg::op_write);
      end
   end

   always_ff @(posedge clk)
   begin
      res_index <= low_index;
   end

endmodule

/* hw/tlb_match_top.sv */
/*
 * Top level of the TLB match unit. Chains decode, execute and result;
 * each command returns its result three clock edges after it is taken
 */
`timescale 1ns/10ps
`include "tlb_consts.svh"

module tlb_match_top (
   input  logic                    clk,
   input  logic                    rst,
   input  logic                    cmd_valid,
   input  tlb_pkg::tlb_op_e        cmd_op,
   input  logic [`TLB_IDX_W-1:0]   cmd_index,
   input  logic [0:`TLB_EPN_W-1]   cmd_epn,
   input  logic [`TLB_SIZE_W-1:0]  cmd_size,
   input  logic                    cmd_xbit,
   input  logic [0:`TLB_CLS_W-1]   cmd_class,
   input  logic                    cmd_gs,
   input  logic                    cmd_ts,
   input  logic [0:`TLB_THD_W-1]   cmd_thdid,
   input  logic [0:`TLB_PID_W-1]   cmd_pid,
   input  logic [0:`TLB_LPID_W-1]  cmd_lpid,
   output logic                    res_valid,
   output tlb_pkg::tlb_op_e        res_op,
   output logic                    res_hit,
   output logic [`TLB_IDX_W-1:0]   res_index,
   output logic                    res_multi,
   output logic                    res_err
);

   tlb_cmd_if cmd_bus ();
   tlb_hit_if hit_bus ();

   tlb_decode u_decode (
      .clk       (clk),
      .rst       (rst),
      .cmd_valid (cmd_valid),
      .cmd_op    (cmd_op),
      .cmd_index (cmd_index),
      .cmd_epn   (cmd_epn),
      .cmd_size  (cmd_size),
      .cmd_xbit  (cmd_xbit),
      .cmd_class (cmd_class),
      .cmd_gs    (cmd_gs),
      .cmd_ts    (cmd_ts),
      .cmd_thdid (cmd_thdid),
      .cmd_pid   (cmd_pid),
      .cmd_lpid  (cmd_lpid),
      .cmd       (cmd_bus)
   );

   tlb_execute u_execute (
      .clk (clk),
      .rst (rst),
      .cmd (cmd_bus),
      .hit (hit_bus)
   );

   tlb_result u_result (
      .clk       (clk),
      .rst       (rst),
      .hit       (hit_bus),
      .res_valid (res_valid),
      .res_op    (res_op),
      .res_hit   (res_hit),
      .res_index (res_index),
      .res_multi (res_multi),
      .res_err   (res_err)
   );

endmodule

/* bench/tlb_checker.sv */
/*
 * Assertions bound into the TLB top level. They watch the result latency
 * and the consistency of the result flags
 */
`timescale 1ns/10ps

module tlb_checker (
   input logic clk,
   input logic rst,
   input logic cmd_valid,
   input logic res_valid,
   input logic res_hit,
   input logic res_multi
);

   // Decode, execute and result each add one register stage
   a_latency : assert property (@(posedge clk) disable iff (rst)
                                res_valid == $past(cmd_valid, 3))
      else $error("res_valid did not follow cmd_valid by three cycles");

   a_multi_hit : assert property (@(posedge clk) disable iff (rst)
                                  res_multi |-> res_hit)
      else $error("res_multi set without res_hit");

   a_reset : assert property (@(posedge clk) $past(rst) |-> !res_valid)
      else $error("res_valid high in the cycle after reset");

endmodule

bind tlb_match_top tlb_checker u_checker (
   .clk       (clk),
   .rst       (rst),
   .cmd_valid (cmd_valid),
   .res_valid (res_valid),
   .res_hit   (res_hit),
   .res_multi (res_multi)
);

/* bench/tlb_tb.sv */
/*
 * Directed testbench for the TLB match unit. Commands are driven on the
 * falling edge, a small entry model predicts each result, and a monitor
 * compares the results in issue order
 */
`timescale 1ns/10ps
`include "tlb_consts.svh"

module tlb_tb;

   localparam int EPN_W      = `TLB_EPN_W;
   localparam int LATENCY    = 3;
   localparam int WAIT_LIMIT = 40;

   // lo is the first EPN bit inside the page, EPN_W for a 4K page
   typedef struct packed {
      logic                   valid;
      logic [0:`TLB_EPN_W-1]  epn;
      int                     lo;
      logic                   xbit;
      logic [0:`TLB_CLS_W-1]  cls;
      logic                   gs;
      logic                   ts;
      logic [0:`TLB_THD_W-1]  thd;
      logic [0:`TLB_PID_W-1]  pid;
      logic [0:`TLB_LPID_W-1] lpid;
   } model_entry_t;

   logic                    clk;
   logic                    rst;
   logic                    cmd_valid;
   tlb_pkg::tlb_op_e        cmd_op;
   logic [`TLB_IDX_W-1:0]   cmd_index;
   logic [0:`TLB_EPN_W-1]   cmd_epn;
   logic [`TLB_SIZE_W-1:0]  cmd_size;
   logic                    cmd_xbit;
   logic [0:`TLB_CLS_W-1]   cmd_class;
   logic                    cmd_gs;
   logic                    cmd_ts;
   logic [0:`TLB_THD_W-1]   cmd_thdid;
   logic [0:`TLB_PID_W-1]   cmd_pid;
   logic [0:`TLB_LPID_W-1]  cmd_lpid;
   logic                    res_valid;
   tlb_pkg::tlb_op_e        res_op;
   logic                    res_hit;
   logic [`TLB_IDX_W-1:0]   res_index;
   logic                    res_multi;
   logic                    res_err;

   // Context carried by the next command
   logic [0:`TLB_CLS_W-1]   ctx_cls;
   logic                    ctx_gs;
   logic                    ctx_ts;
   logic [0:`TLB_THD_W-1]   ctx_thd;
   logic [0:`TLB_PID_W-1]   ctx_pid;
   logic [0:`TLB_LPID_W-1]  ctx_lpid;

   model_entry_t            model [`TLB_ENTRIES];
   // Expected {op, hit, index, multi, err} and the cycle of each command
   logic [6:0]              exp_q [$];
   int                      cyc_q [$];
   logic [6:0]              exp_v;
   logic [6:0]              got_v;
   int                      issued;
   int                      cyc;
   int                      errors;
   int                      mark;
   int                      tests_run;
   int                      tests_bad;
   logic                    hung;
   string                   test_name;

   tlb_match_top UUT (
      .clk       (clk),
      .rst       (rst),
      .cmd_valid (cmd_valid),
      .cmd_op    (cmd_op),
      .cmd_index (cmd_index),
      .cmd_epn   (cmd_epn),
      .cmd_size  (cmd_size),
      .cmd_xbit  (cmd_xbit),
      .cmd_class (cmd_class),
      .cmd_gs    (cmd_gs),
      .cmd_ts    (cmd_ts),
      .cmd_thdid (cmd_thdid),
      .cmd_pid   (cmd_pid),
      .cmd_lpid  (cmd_lpid),
      .res_valid (res_valid),
      .res_op    (res_op),
      .res_hit   (res_hit),
      .res_index (res_index),
      .res_multi (res_multi),
      .res_err   (res_err)
   );

   initial
   begin
      clk = 1'b0;
      forever
      begin
         #10 clk = ~clk;
      end
   end

   always @(posedge clk)
   begin
      cyc <= cyc + 1;
   end

   // Outputs settle after the rising edge, so they are read on the falling one
   always @(negedge clk)
   begin
      if (!rst && res_valid)
      begin
         if (exp_q.size() == 0)
         begin
            $display("%s: a result arrived with no command outstanding", test_name);
            errors++;
         end
         else
         begin
            exp_v  = exp_q.pop_front();
            issued = cyc_q.pop_front();
            got_v  = {res_op, res_hit, res_index, res_multi, res_err};
            if (got_v !== exp_v)
            begin
               $display("error %s: result {op,hit,index,multi,err} expected %b actual %b",
                        test_name, exp_v, got_v);
               errors++;
            end
            if (cyc - issued != LATENCY)
            begin
               $display("error %s: latency expected %0d actual %0d",
                        test_name, LATENCY, cyc - issued);
               errors++;
            end
         end
      end
   end

   function automatic int page_lo(logic [`TLB_SIZE_W-1:0] size);
      case (size)
         4'b0001: return EPN_W;
         4'b0011: return 48;
         4'b0101: return 44;
         4'b0111: return 40;
         4'b1001: return 36;
         4'b1010: return 34;
         default: return -1;
      endcase
   endfunction

   function automatic logic [0:`TLB_EPN_W-1] rand_epn();
      return `TLB_EPN_W'({$urandom, $urandom});
   endfunction

   function automatic logic model_match(model_entry_t m, logic [0:`TLB_EPN_W-1] addr,
                                        logic search);
      logic outside;
      outside = 1'b0;
      if (!m.valid)
      begin
         return 1'b0;
      end
      for (int b = 0; b < m.lo; b++)
      begin
         if (addr[b] != m.epn[b])
         begin
            return 1'b0;
         end
      end
      // An excluded page still matches where the address has a one over an EPN zero
      for (int b = m.lo; b < EPN_W; b++)
      begin
         if (addr[b] && !m.epn[b])
         begin
            outside = 1'b1;
         end
      end
      if (m.xbit && m.lo < EPN_W && !outside)
      begin
         return 1'b0;
      end
      if (search && (m.cls != ctx_cls || m.gs != ctx_gs || m.ts != ctx_ts
                     || (m.thd & ctx_thd) == '0))
      begin
         return 1'b0;
      end
      if (m.pid != ctx_pid && !(search && m.pid == '0))
      begin
         return 1'b0;
      end
      if (m.lpid != ctx_lpid && !(search && m.lpid == '0))
      begin
         return 1'b0;
      end
      return 1'b1;
   endfunction

   task automatic send_cmd(tlb_pkg::tlb_op_e op, int index, logic [0:`TLB_EPN_W-1] epn,
                           logic [`TLB_SIZE_W-1:0] size, logic xbit);
      logic [`TLB_ENTRIES-1:0] hv;
      logic [`TLB_IDX_W-1:0]   low;
      logic                    found;
      int                      lo;
      @(negedge clk);
      cmd_valid = 1'b1;
      cmd_op    = op;
      cmd_index = `TLB_IDX_W'(index);
      cmd_epn   = epn;
      cmd_size  = size;
      cmd_xbit  = xbit;
      cmd_class = ctx_cls;
      cmd_gs    = ctx_gs;
      cmd_ts    = ctx_ts;
      cmd_thdid = ctx_thd;
      cmd_pid   = ctx_pid;
      cmd_lpid  = ctx_lpid;
      hv    = '0;
      low   = '0;
      found = 1'b0;
      lo    = page_lo(size);
      if (op == tlb_pkg::op_write)
      begin
         if (lo >= 0)
         begin
            model[index] = '{1'b1, epn, lo, xbit, ctx_cls, ctx_gs, ctx_ts, ctx_thd,
                             ctx_pid, ctx_lpid};
         end
         exp_q.push_back({op, 4'b0000, (lo < 0)});
      end
      else
      begin
         for (int k = 0; k < `TLB_ENTRIES; k++)
         begin
            hv[k] = model_match(model[k], epn, op == tlb_pkg::op_search);
            if (hv[k] && !found)
            begin
               low   = `TLB_IDX_W'(k);
               found = 1'b1;
            end
         end
         for (int k = 0; k < `TLB_ENTRIES; k++)
         begin
            if (op == tlb_pkg::op_invalidate && hv[k])
            begin
               model[k].valid = 1'b0;
            end
         end
         exp_q.push_back({op, found, low, ($countones(hv) > 1), 1'b0});
      end
      cyc_q.push_back(cyc);
   endtask

   task automatic write_entry(int index, logic [0:`TLB_EPN_W-1] epn,
                              logic [`TLB_SIZE_W-1:0] size, logic xbit);
      send_cmd(tlb_pkg::op_write, index, epn, size, xbit);
   endtask

   task automatic search_addr(logic [0:`TLB_EPN_W-1] epn);
      send_cmd(tlb_pkg::op_search, 0, epn, tlb_pkg::size_4k, 1'b0);
   endtask

   task automatic invalidate_addr(logic [0:`TLB_EPN_W-1] epn);
      send_cmd(tlb_pkg::op_invalidate, 0, epn, tlb_pkg::size_4k, 1'b0);
   endtask

   task automatic wait_results();
      int waited;
      waited = 0;
      @(negedge clk);
      cmd_valid = 1'b0;
      cmd_op    = tlb_pkg::op_nop;
      while (exp_q.size() != 0 && waited < WAIT_LIMIT && !hung)
      begin
         @(negedge clk);
         waited++;
      end
      if (exp_q.size() != 0 && !hung)
      begin
         $display("%s: timed out with %0d results still missing", test_name, exp_q.size());
         hung = 1'b1;
      end
   endtask

   task automatic reset_dut();
      rst       = 1'b1;
      cmd_valid = 1'b0;
      repeat (10) @(posedge clk);
      @(negedge clk);
      rst = 1'b0;
      for (int k = 0; k < `TLB_ENTRIES; k++)
      begin
         model[k].valid = 1'b0;
      end
   endtask

   task automatic start_test(string name);
      test_name = name;
      mark      = errors;
      ctx_cls   = 2'b01;
      ctx_gs    = 1'b0;
      ctx_ts    = 1'b1;
      ctx_thd   = 4'b0011;
      ctx_pid   = `TLB_PID_W'($urandom_range(1, 16383));
      ctx_lpid  = `TLB_LPID_W'($urandom_range(1, 255));
      reset_dut();
   endtask

   task automatic end_test();
      wait_results();
      tests_run++;
      if (hung || errors != mark)
      begin
         tests_bad++;
         $display("%s: %0d errors", test_name, errors - mark);
      end
      else
      begin
         $display("%s: ok", test_name);
      end
   endtask

   task automatic basic_write_search();
      logic [0:`TLB_EPN_W-1] a;
      start_test("basic_write_search");
      a = rand_epn();
      search_addr(a);
      wait_results();
      write_entry(2, a, tlb_pkg::size_4k, 1'b0);
      search_addr(a);
      end_test();
   endtask

   task automatic page_sizes();
      logic [`TLB_SIZE_W-1:0] sizes [6];
      logic [0:`TLB_EPN_W-1]  base;
      logic [0:`TLB_EPN_W-1]  a;
      int                     lo;
      start_test("page_sizes");
      sizes = '{tlb_pkg::size_4k, tlb_pkg::size_64k, tlb_pkg::size_1m,
                tlb_pkg::size_16m, tlb_pkg::size_256m, tlb_pkg::size_1g};
      for (int s = 0; s < 6; s++)
      begin
         base = rand_epn();
         lo   = page_lo(sizes[s]);
         write_entry(s % `TLB_ENTRIES, base, sizes[s], 1'b0);
         a = base;
         if (lo < EPN_W)
         begin
            a[lo]      = ~a[lo];
            a[EPN_W-1] = ~a[EPN_W-1];
         end
         search_addr(a);
         a        = base;
         a[lo-1]  = ~a[lo-1];
         search_addr(a);
      end
      end_test();
   endtask

   task automatic context_fields();
      logic [0:`TLB_EPN_W-1]  a;
      logic [0:`TLB_EPN_W-1]  b;
      logic [0:`TLB_PID_W-1]  pid_keep;
      logic [0:`TLB_LPID_W-1] lpid_keep;
      start_test("context_fields");
      a = rand_epn();
      b = rand_epn();
      write_entry(1, a, tlb_pkg::size_4k, 1'b0);
      ctx_pid[0] = ~ctx_pid[0];
      search_addr(a);
      ctx_pid[0]  = ~ctx_pid[0];
      ctx_lpid[0] = ~ctx_lpid[0];
      search_addr(a);
      ctx_lpid[0] = ~ctx_lpid[0];
      ctx_thd     = 4'b1100;
      search_addr(a);
      ctx_thd = 4'b0110;
      search_addr(a);
      ctx_thd = 4'b0011;
      ctx_cls = ~ctx_cls;
      search_addr(a);
      ctx_cls = ~ctx_cls;
      ctx_gs  = ~ctx_gs;
      search_addr(a);
      ctx_gs    = ~ctx_gs;
      pid_keep  = ctx_pid;
      lpid_keep = ctx_lpid;
      ctx_pid   = '0;
      ctx_lpid  = '0;
      write_entry(2, b, tlb_pkg::size_4k, 1'b0);
      ctx_pid  = pid_keep;
      ctx_lpid = lpid_keep;
      search_addr(b);
      end_test();
   endtask

   task automatic invalidate_entries();
      logic [0:`TLB_EPN_W-1] a;
      logic [0:`TLB_EPN_W-1] b;
      logic [0:`TLB_PID_W-1] pid_keep;
      start_test("invalidate_entries");
      a = rand_epn();
      b = rand_epn();
      write_entry(0, a, tlb_pkg::size_4k, 1'b0);
      // Invalidate does not look at class
      ctx_cls = ~ctx_cls;
      invalidate_addr(a);
      ctx_cls = ~ctx_cls;
      search_addr(a);
      pid_keep = ctx_pid;
      ctx_pid  = '0;
      write_entry(3, b, tlb_pkg::size_4k, 1'b0);
      ctx_pid = pid_keep;
      invalidate_addr(b);
      search_addr(b);
      end_test();
   endtask

   task automatic exclusion_and_size();
      logic [0:`TLB_EPN_W-1] e;
      logic [0:`TLB_EPN_W-1] a;
      logic [0:`TLB_EPN_W-1] f;
      start_test("exclusion_and_size");
      e = rand_epn();
      e[`TLB_G64K_LO +: 4] = 4'b1010;
      write_entry(1, e, tlb_pkg::size_64k, 1'b1);
      a = e;
      a[`TLB_G64K_LO +: 4] = 4'b1000;
      search_addr(a);
      a[`TLB_G64K_LO +: 4] = 4'b0100;
      search_addr(a);
      f = rand_epn();
      write_entry(2, f, 4'b1111, 1'b0);
      search_addr(f);
      end_test();
   endtask

   task automatic back_to_back();
      logic [0:`TLB_EPN_W-1] a;
      logic [0:`TLB_EPN_W-1] b;
      start_test("back_to_back");
      a = rand_epn();
      b = a;
      // b lies inside a's 1M page but is a different 4K page
      b[`TLB_G1M_LO +: 8] = ~a[`TLB_G1M_LO +: 8];
      write_entry(1, a, tlb_pkg::size_1m, 1'b0);
      write_entry(3, b, tlb_pkg::size_4k, 1'b0);
      search_addr(b);
      search_addr(a);
      search_addr(rand_epn());
      search_addr(b);
      end_test();
   endtask

   initial
   begin
      rst       = 1'b1;
      cmd_valid = 1'b0;
      cmd_op    = tlb_pkg::op_nop;
      cmd_index = '0;
      cmd_epn   = '0;
      cmd_size  = '0;
      cmd_xbit  = 1'b0;
      cmd_class = '0;
      cmd_gs    = 1'b0;
      cmd_ts    = 1'b0;
      cmd_thdid = '0;
      cmd_pid   = '0;
      cmd_lpid  = '0;
      cyc       = 0;
      errors    = 0;
      tests_run = 0;
      tests_bad = 0;
      hung      = 1'b0;
      test_name = "reset";
      void'($urandom(90));
      for (int t = 0; t < 6 && !hung; t++)
      begin
         case (t)
            0: basic_write_search();
            1: page_sizes();
            2: context_fields();
            3: invalidate_entries();
            4: exclusion_and_size();
            default: back_to_back();
         endcase
      end
      $display("tests run %0d, tests with errors %0d, total errors %0d",
               tests_run, tests_bad, errors);
      if (errors == 0 && !hung)
      begin
         $display("Test completed successfully");
      end
      else
      begin
         $display("Test failed");
      end
      $finish;
   end

endmodule

/* build.f */
+incdir+hw
hw/tlb_pkg.sv
hw/tlb_ifs.sv
hw/tlb_decode.sv
hw/tlb_execute.sv
hw/tlb_result.sv
hw/tlb_match_top.sv
bench/tlb_checker.sv
bench/tlb_tb.sv

/* run.sh */
#!/bin/sh
# Builds the TLB match unit and its testbench with Verilator, then runs it.
# The run passes only when the simulation prints its pass message.
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --top-module tlb_tb -f build.f -o tlb_sim

out=$(./obj_dir/tlb_sim 2>&1) || true
echo "$out"

if echo "$out" | grep -q "Test completed successfully"
then
   exit 0
fi
exit 1
